/* mips_pkg.sv */
package mips_pkg;

    localparam int NB_DATA = 32;
    localparam int NB_REG  = 5;
    localparam int NB_OP   = 6;
    localparam int NB_IMM  = 16;

    localparam logic [NB_OP-1:0] OP_RTYPE = 6'h00;
    localparam logic [NB_OP-1:0] OP_JAL   = 6'h03;
    localparam logic [NB_OP-1:0] OP_BEQ   = 6'h04;
    localparam logic [NB_OP-1:0] OP_BNE   = 6'h05;
    localparam logic [NB_OP-1:0] OP_ADDIU = 6'h09;
    localparam logic [NB_OP-1:0] OP_ANDI  = 6'h0c;
    localparam logic [NB_OP-1:0] OP_ORI   = 6'h0d;
    localparam logic [NB_OP-1:0] OP_LUI   = 6'h0f;
    localparam logic [NB_OP-1:0] OP_LB    = 6'h20;
    localparam logic [NB_OP-1:0] OP_LH    = 6'h21;
    localparam logic [NB_OP-1:0] OP_LW    = 6'h23;
    localparam logic [NB_OP-1:0] OP_LBU   = 6'h24;
    localparam logic [NB_OP-1:0] OP_LHU   = 6'h25;
    localparam logic [NB_OP-1:0] OP_SB    = 6'h28;
    localparam logic [NB_OP-1:0] OP_SH    = 6'h29;
    localparam logic [NB_OP-1:0] OP_SW    = 6'h2b;
    localparam logic [NB_OP-1:0] OP_HLT   = 6'h3f;

    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_JR   = 6'h08;
    localparam logic [5:0] FN_JALR = 6'h09;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    typedef struct packed {
        logic [NB_OP-1:0]  opcode;
        logic [NB_REG-1:0] rs;
        logic [NB_REG-1:0] rt;
        logic [NB_REG-1:0] rd;
        logic [NB_REG-1:0] shamt;
        logic [5:0]        funct;
    } r_fields_t;

    typedef struct packed {
        logic [NB_OP-1:0]  opcode;
        logic [NB_REG-1:0] rs;
        logic [NB_REG-1:0] rt;
        logic [NB_IMM-1:0] imm16;
    } i_fields_t;

    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_t;

endpackage

/* mem_pkg.sv */
package mem_pkg;

    localparam int NB_BYTE = 8;
    localparam int NB_ACC  = 3;

    // Size enables in {word, halfword, byte} order.
    localparam logic [NB_ACC-1:0] ACC_NONE = 3'b000;
    localparam logic [NB_ACC-1:0] ACC_BYTE = 3'b001;
    localparam logic [NB_ACC-1:0] ACC_HALF = 3'b010;
    localparam logic [NB_ACC-1:0] ACC_WORD = 3'b100;

    localparam int MEM_ADDR_BITS = 8; // 256 bytes.

endpackage

/* ex_stage.sv */
`timescale 1ns/1ns

module ex_stage (
    input  mips_pkg::instr_t                instr,
    input  logic [mips_pkg::NB_DATA-1:0]    rs_data,
    input  logic [mips_pkg::NB_DATA-1:0]    rt_data,
    input  logic [mips_pkg::NB_DATA-1:0]    pc,
    output logic                            ex_signed,
    output logic                            ex_reg_write,
    output logic                            ex_mem_to_reg,
    output logic                            ex_mem_read,
    output logic                            ex_mem_write,
    output logic                            ex_branch,
    output logic [mips_pkg::NB_DATA-1:0]    ex_branch_addr,
    output logic                            ex_zero,
    output logic [mips_pkg::NB_DATA-1:0]    ex_alu_result,
    output logic [mips_pkg::NB_DATA-1:0]    ex_data_b,
    output logic [mips_pkg::NB_REG-1:0]     ex_selected_reg,
    output logic                            ex_byte_en,
    output logic                            ex_halfword_en,
    output logic                            ex_word_en,
    output logic                            ex_r31_ctrl,
    output logic [mips_pkg::NB_DATA-1:0]    ex_pc,
    output logic                            ex_hlt,
    output logic                            ex_jump,
    output logic                            ex_jr_jalr
);

    localparam int NB = mips_pkg::NB_DATA;

    logic [NB-1:0]               imm_sext;
    logic [NB-1:0]               imm_zext;
    logic [NB-1:0]               pc_plus4;
    logic [mem_pkg::NB_ACC-1:0]  size;
    logic                        eq;

    assign imm_sext  = {{(NB-16){instr.i.imm16[15]}}, instr.i.imm16};
    assign imm_zext  = {{(NB-16){1'b0}}, instr.i.imm16};
    assign pc_plus4  = pc + NB'(4);
    assign eq        = (rs_data == rt_data);
    assign ex_pc     = pc;
    assign ex_data_b = rt_data; // Store data.

    assign {ex_word_en, ex_halfword_en, ex_byte_en} = size;

    always_comb begin
        ex_signed       = 1'b0;
        ex_reg_write    = 1'b0;
        ex_mem_to_reg   = 1'b0;
        ex_mem_read     = 1'b0;
        ex_mem_write    = 1'b0;
        ex_branch       = 1'b0;
        ex_zero         = 1'b0;
        ex_r31_ctrl     = 1'b0;
        ex_hlt          = 1'b0;
        ex_jump         = 1'b0;
        ex_jr_jalr      = 1'b0;
        size            = mem_pkg::ACC_NONE;
        ex_alu_result   = '0;
        ex_selected_reg = instr.r.rd;
        ex_branch_addr  = pc_plus4 + (imm_sext << 2);
        case (instr.r.opcode)
            mips_pkg::OP_RTYPE: begin
                ex_reg_write = 1'b1;
                case (instr.r.funct)
                    mips_pkg::FN_ADDU: ex_alu_result = rs_data + rt_data;
                    mips_pkg::FN_SUBU: ex_alu_result = rs_data - rt_data;
                    mips_pkg::FN_AND:  ex_alu_result = rs_data & rt_data;
                    mips_pkg::FN_OR:   ex_alu_result = rs_data | rt_data;
                    mips_pkg::FN_XOR:  ex_alu_result = rs_data ^ rt_data;
                    mips_pkg::FN_SLT:  ex_alu_result = NB'($signed(rs_data) < $signed(rt_data));
                    mips_pkg::FN_SLL:  ex_alu_result = rt_data << instr.r.shamt;
                    mips_pkg::FN_JR: begin
                        ex_reg_write   = 1'b0;
                        ex_jr_jalr     = 1'b1;
                        ex_branch_addr = rs_data;
                    end
                    mips_pkg::FN_JALR: begin
                        ex_jr_jalr     = 1'b1;
                        ex_branch_addr = rs_data;
                        ex_alu_result  = pc + NB'(8); // Link address.
                    end
                    default: ex_reg_write = 1'b0;
                endcase
            end
            mips_pkg::OP_ADDIU, mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_LUI: begin
                ex_reg_write    = 1'b1;
                ex_selected_reg = instr.i.rt;
                case (instr.i.opcode)
                    mips_pkg::OP_ADDIU: ex_alu_result = rs_data + imm_sext;
                    mips_pkg::OP_ANDI:  ex_alu_result = rs_data & imm_zext;
                    mips_pkg::OP_ORI:   ex_alu_result = rs_data | imm_zext;
                    default:            ex_alu_result = imm_zext << 16;
                endcase
            end
            mips_pkg::OP_LB, mips_pkg::OP_LH, mips_pkg::OP_LW,
            mips_pkg::OP_LBU, mips_pkg::OP_LHU: begin
                ex_reg_write    = 1'b1;
                ex_mem_to_reg   = 1'b1;
                ex_mem_read     = 1'b1;
                ex_selected_reg = instr.i.rt;
                ex_alu_result   = rs_data + imm_sext;
                ex_signed = (instr.i.opcode == mips_pkg::OP_LB) ||
                            (instr.i.opcode == mips_pkg::OP_LH);
                case (instr.i.opcode)
                    mips_pkg::OP_LW:                  size = mem_pkg::ACC_WORD;
                    mips_pkg::OP_LH, mips_pkg::OP_LHU: size = mem_pkg::ACC_HALF;
                    default:                          size = mem_pkg::ACC_BYTE;
                endcase
            end
            mips_pkg::OP_SB, mips_pkg::OP_SH, mips_pkg::OP_SW: begin
                ex_mem_write  = 1'b1;
                ex_alu_result = rs_data + imm_sext;
                case (instr.i.opcode)
                    mips_pkg::OP_SW: size = mem_pkg::ACC_WORD;
                    mips_pkg::OP_SH: size = mem_pkg::ACC_HALF;
                    default:         size = mem_pkg::ACC_BYTE;
                endcase
            end
            mips_pkg::OP_BEQ, mips_pkg::OP_BNE: begin
                ex_branch     = 1'b1;
                ex_alu_result = rs_data - rt_data;
                ex_zero = (instr.i.opcode == mips_pkg::OP_BNE) ? !eq : eq; // Taken when set.
            end
            mips_pkg::OP_JAL: begin
                ex_jump         = 1'b1;
                ex_r31_ctrl     = 1'b1;
                ex_reg_write    = 1'b1;
                ex_selected_reg = '1; // r31.
                ex_alu_result   = pc + NB'(8);
                ex_branch_addr  = {pc_plus4[NB-1:28], instr.i.rs, instr.i.rt,
                                   instr.i.imm16, 2'b00};
            end
            mips_pkg::OP_HLT: ex_hlt = 1'b1;
            default: ;
        endcase
    end

endmodule

/* ex_mem_reg.sv */
`timescale 1ns/1ns

module ex_mem_reg #(
    parameter int NB_PC  = 32,
    parameter int NB_REG = 5
) (
    input  logic                i_clock,
    input  logic                i_reset,
    input  logic                pipeline_enable,
    input  logic                flush,
    input  logic                ex_signed,
    input  logic                ex_reg_write,
    input  logic                ex_mem_to_reg,
    input  logic                ex_mem_read,
    input  logic                ex_mem_write,
    input  logic                ex_branch,
    input  logic [NB_PC-1:0]    ex_branch_addr,
    input  logic                ex_zero,
    input  logic [NB_PC-1:0]    ex_alu_result,
    input  logic [NB_PC-1:0]    ex_data_b,
    input  logic [NB_REG-1:0]   ex_selected_reg,
    input  logic                ex_byte_en,
    input  logic                ex_halfword_en,
    input  logic                ex_word_en,
    input  logic                ex_r31_ctrl,
    input  logic [NB_PC-1:0]    ex_pc,
    input  logic                ex_hlt,
    input  logic                ex_jump,
    input  logic                ex_jr_jalr,
    output logic                mem_signed,
    output logic                mem_reg_write,
    output logic                mem_mem_to_reg,
    output logic                mem_mem_read,
    output logic                mem_mem_write,
    output logic                mem_branch,
    output logic [NB_PC-1:0]    mem_branch_addr,
    output logic                mem_zero,
    output logic [NB_PC-1:0]    mem_alu_result,
    output logic [NB_PC-1:0]    mem_data_b,
    output logic [NB_REG-1:0]   mem_selected_reg,
    output logic                mem_byte_en,
    output logic                mem_halfword_en,
    output logic                mem_word_en,
    output logic                mem_r31_ctrl,
    output logic [NB_PC-1:0]    mem_pc,
    output logic                mem_hlt,
    output logic                mem_jump,
    output logic                mem_jr_jalr
);

    localparam int NB_CTRL    = 14;
    localparam int NB_PAYLOAD = 4*NB_PC + NB_REG;

    logic [NB_CTRL-1:0]    ctrl_q;
    logic [NB_PAYLOAD-1:0] data_q;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            ctrl_q <= '0;
            data_q <= '0;
        end else if (pipeline_enable) begin // Hold when disabled.
            ctrl_q <= flush ? '0 : {ex_signed, ex_reg_write, ex_mem_to_reg, ex_mem_read,
                                    ex_mem_write, ex_branch, ex_zero, ex_byte_en,
                                    ex_halfword_en, ex_word_en, ex_r31_ctrl, ex_hlt,
                                    ex_jump, ex_jr_jalr};
            data_q <= {ex_branch_addr, ex_alu_result, ex_data_b, ex_selected_reg, ex_pc};
        end
    end

    assign {mem_signed, mem_reg_write, mem_mem_to_reg, mem_mem_read, mem_mem_write,
            mem_branch, mem_zero, mem_byte_en, mem_halfword_en, mem_word_en,
            mem_r31_ctrl, mem_hlt, mem_jump, mem_jr_jalr} = ctrl_q;

    assign {mem_branch_addr, mem_alu_result, mem_data_b, mem_selected_reg, mem_pc} = data_q;

endmodule

/* mem_stage.sv */
`timescale 1ns/1ns

module mem_stage #(
    parameter int NB_ADDR = 8
) (
    input  logic                            i_clock,
    input  logic                            pipeline_enable,
    input  logic                            mem_signed,
    input  logic                            mem_reg_write,
    input  logic                            mem_mem_to_reg,
    input  logic                            mem_mem_read,
    input  logic                            mem_mem_write,
    input  logic                            mem_branch,
    input  logic [mips_pkg::NB_DATA-1:0]    mem_branch_addr,
    input  logic                            mem_zero,
    input  logic [mips_pkg::NB_DATA-1:0]    mem_alu_result,
    input  logic [mips_pkg::NB_DATA-1:0]    mem_data_b,
    input  logic [mips_pkg::NB_REG-1:0]     mem_selected_reg,
    input  logic                            mem_byte_en,
    input  logic                            mem_halfword_en,
    input  logic                            mem_word_en,
    input  logic                            mem_r31_ctrl,
    input  logic [mips_pkg::NB_DATA-1:0]    mem_pc,
    input  logic                            mem_jump,
    input  logic                            mem_jr_jalr,
    output logic [mips_pkg::NB_DATA-1:0]    wb_data,
    output logic [mips_pkg::NB_REG-1:0]     wb_reg,
    output logic                            wb_write,
    output logic                            branch_taken,
    output logic [mips_pkg::NB_DATA-1:0]    branch_target
);

    localparam int NB    = mips_pkg::NB_DATA;
    localparam int NB_B  = mem_pkg::NB_BYTE;
    localparam int DEPTH = 2**NB_ADDR;

    logic [NB_B-1:0]    mem [DEPTH];
    logic [NB_ADDR-1:0] addr;
    logic [NB_ADDR-1:0] h0, h1;
    logic [NB_ADDR-1:0] w0, w1, w2, w3;
    logic [NB-1:0]      load_data;

    assign addr = mem_alu_result[NB_ADDR-1:0];
    assign h0   = {addr[NB_ADDR-1:1], 1'b0}; // Aligned halfword.
    assign h1   = {addr[NB_ADDR-1:1], 1'b1};
    assign w0   = {addr[NB_ADDR-1:2], 2'd0}; // Aligned word.
    assign w1   = {addr[NB_ADDR-1:2], 2'd1};
    assign w2   = {addr[NB_ADDR-1:2], 2'd2};
    assign w3   = {addr[NB_ADDR-1:2], 2'd3};

    always_ff @(posedge i_clock) begin
        if (pipeline_enable && mem_mem_write) begin
            if (mem_byte_en) begin
                mem[addr] <= mem_data_b[7:0];
            end
            if (mem_halfword_en) begin
                mem[h0] <= mem_data_b[7:0];
                mem[h1] <= mem_data_b[15:8];
            end
            if (mem_word_en) begin
                mem[w0] <= mem_data_b[7:0];
                mem[w1] <= mem_data_b[15:8];
                mem[w2] <= mem_data_b[23:16];
                mem[w3] <= mem_data_b[31:24];
            end
        end
    end

    // Little endian load with extension by the signed flag.
    always_comb begin
        if (mem_word_en) begin
            load_data = {mem[w3], mem[w2], mem[w1], mem[w0]};
        end else if (mem_halfword_en) begin
            load_data = {{(NB-16){mem_signed & mem[h1][7]}}, mem[h1], mem[h0]};
        end else begin
            load_data = {{(NB-8){mem_signed & mem[addr][7]}}, mem[addr]};
        end
    end

    assign wb_data  = (mem_mem_to_reg && mem_mem_read) ? load_data : mem_alu_result;
    assign wb_reg   = mem_selected_reg;
    assign wb_write = mem_reg_write;

    assign branch_taken  = (mem_branch & mem_zero) | mem_jump | mem_jr_jalr;
    assign branch_target = mem_branch_addr;

endmodule

/* debug_ctrl.sv */
`timescale 1ns/1ns

module debug_ctrl (
    input  logic i_clock,
    input  logic i_reset,
    input  logic cfg_write,
    input  logic cfg_step_mode,
    input  logic step,
    input  logic mem_hlt,
    output logic pipeline_enable,
    output logic halted
);

    logic step_mode;
    logic step_q;
    logic halt_q;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            step_mode <= 1'b0; // Run mode.
            step_q    <= 1'b0;
            halt_q    <= 1'b0;
        end else begin
            if (cfg_write) begin
                step_mode <= cfg_step_mode;
            end
            step_q <= step;
            if (mem_hlt) begin
                halt_q <= 1'b1; // Sticky until reset.
            end
        end
    end

    assign halted          = halt_q | mem_hlt;
    assign pipeline_enable = !halted && (!step_mode || step_q);

endmodule

/* ex_mem_top.sv */
`timescale 1ns/1ns

module ex_mem_top #(
    parameter int NB_ADDR = mem_pkg::MEM_ADDR_BITS
) (
    input  logic                            i_clock,
    input  logic                            i_reset,
    input  mips_pkg::instr_t                instr,
    input  logic [mips_pkg::NB_DATA-1:0]    rs_data,
    input  logic [mips_pkg::NB_DATA-1:0]    rt_data,
    input  logic [mips_pkg::NB_DATA-1:0]    pc,
    input  logic                            flush,
    input  logic                            cfg_write,
    input  logic                            cfg_step_mode,
    input  logic                            step,
    output logic [mips_pkg::NB_DATA-1:0]    wb_data,
    output logic [mips_pkg::NB_REG-1:0]     wb_reg,
    output logic                            wb_write,
    output logic                            branch_taken,
    output logic [mips_pkg::NB_DATA-1:0]    branch_target,
    output logic                            halted
);

    logic ex_signed, ex_reg_write, ex_mem_to_reg, ex_mem_read, ex_mem_write, ex_branch;
    logic ex_zero, ex_byte_en, ex_halfword_en, ex_word_en, ex_r31_ctrl, ex_hlt;
    logic ex_jump, ex_jr_jalr;
    logic [mips_pkg::NB_DATA-1:0] ex_branch_addr, ex_alu_result, ex_data_b, ex_pc;
    logic [mips_pkg::NB_REG-1:0]  ex_selected_reg;

    logic mem_signed, mem_reg_write, mem_mem_to_reg, mem_mem_read, mem_mem_write;
    logic mem_branch, mem_zero, mem_byte_en, mem_halfword_en, mem_word_en;
    logic mem_r31_ctrl, mem_hlt, mem_jump, mem_jr_jalr;
    logic [mips_pkg::NB_DATA-1:0] mem_branch_addr, mem_alu_result, mem_data_b, mem_pc;
    logic [mips_pkg::NB_REG-1:0]  mem_selected_reg;

    logic pipeline_enable;

    ex_stage ex_stage_i (.*);

    ex_mem_reg #(
        .NB_PC  (mips_pkg::NB_DATA),
        .NB_REG (mips_pkg::NB_REG)
    ) ex_mem_reg_i (.*);

    mem_stage #(
        .NB_ADDR (NB_ADDR)
    ) mem_stage_i (.*);

    debug_ctrl debug_ctrl_i (.*);

endmodule

/* tb_ex_mem.sv */
`timescale 1ns/1ns

module tb_ex_mem;

    localparam int NB_ADDR = 8;
    localparam int LIMIT   = 400*3 + 200; // Cycles.

    typedef struct packed {
        logic [31:0] data;
        logic [4:0]  wreg;
        logic        write;
        logic        taken;
        logic [31:0] target;
        logic        halt;
    } exp_t;

    logic             i_clock;
    logic             i_reset;
    mips_pkg::instr_t instr;
    logic [31:0]      rs_data;
    logic [31:0]      rt_data;
    logic [31:0]      pc;
    logic             flush;
    logic             cfg_write;
    logic             cfg_step_mode;
    logic             step;
    logic [31:0]      wb_data;
    logic [4:0]       wb_reg;
    logic             wb_write;
    logic             branch_taken;
    logic [31:0]      branch_target;
    logic             halted;

    logic [7:0] model_mem [256];
    exp_t       exp_q [$];
    int         due_q [$];
    string      name_q [$];
    int         cycles = 0;
    exp_t       last_exp;

    ex_mem_top #(.NB_ADDR(NB_ADDR)) ex_mem_top_i (.*);

    initial begin
        i_clock = 1'b0;
        forever #5 i_clock = ~i_clock;
    end

    always @(posedge i_clock) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout after %0d cycles with %0d checks pending.", cycles, due_q.size());
            $display("test failed");
            $fatal(1, "Simulation stopped by timeout.");
        end
    end

    task automatic check(input string name, input string field, input logic [31:0] expv,
                         input logic [31:0] act);
        if (expv !== act) begin
            $display("MISMATCH %s %s expected %h actual %h", name, field, expv, act);
            $display("test failed");
            $fatal(1, "Compare error.");
        end
    endtask

    // Expected outputs from the instruction encoding and the memory model.
    function automatic exp_t ref_result(logic [31:0] ins, logic [31:0] a, logic [31:0] b,
                                        logic [31:0] p, logic fl);
        exp_t        r;
        logic [31:0] sext;
        logic [31:0] alu;
        logic [31:0] load;
        logic [31:0] p4;
        logic [7:0]  ad;
        logic        loadop;
        sext   = {{16{ins[15]}}, ins[15:0]};
        p4     = p + 32'd4;
        alu    = '0;
        load   = '0;
        loadop = 1'b0;
        r.wreg   = ins[15:11];
        r.write  = 1'b0;
        r.taken  = 1'b0;
        r.target = p4 + (sext << 2);
        r.halt   = (ins[31:26] == mips_pkg::OP_HLT) && !fl;
        case (ins[31:26])
            mips_pkg::OP_RTYPE: begin
                r.write = 1'b1;
                case (ins[5:0])
                    mips_pkg::FN_ADDU: alu = a + b;
                    mips_pkg::FN_SUBU: alu = a - b;
                    mips_pkg::FN_AND:  alu = a & b;
                    mips_pkg::FN_OR:   alu = a | b;
                    mips_pkg::FN_XOR:  alu = a ^ b;
                    mips_pkg::FN_SLT:  alu = {31'b0, $signed(a) < $signed(b)};
                    mips_pkg::FN_SLL:  alu = b << ins[10:6];
                    mips_pkg::FN_JR: begin
                        r.write  = 1'b0;
                        r.taken  = 1'b1;
                        r.target = a;
                    end
                    mips_pkg::FN_JALR: begin
                        r.taken  = 1'b1;
                        r.target = a;
                        alu      = p + 32'd8;
                    end
                    default: r.write = 1'b0;
                endcase
            end
            mips_pkg::OP_ADDIU, mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_LUI: begin
                r.write = 1'b1;
                r.wreg  = ins[20:16];
                case (ins[31:26])
                    mips_pkg::OP_ADDIU: alu = a + sext;
                    mips_pkg::OP_ANDI:  alu = a & {16'h0, ins[15:0]};
                    mips_pkg::OP_ORI:   alu = a | {16'h0, ins[15:0]};
                    default:            alu = {ins[15:0], 16'h0};
                endcase
            end
            mips_pkg::OP_LB, mips_pkg::OP_LBU, mips_pkg::OP_LH, mips_pkg::OP_LHU,
            mips_pkg::OP_LW: begin
                r.write = 1'b1;
                r.wreg  = ins[20:16];
                alu     = a + sext;
                ad      = alu[7:0];
                loadop  = 1'b1;
                case (ins[31:26])
                    mips_pkg::OP_LB:  load = {{24{model_mem[ad][7]}}, model_mem[ad]};
                    mips_pkg::OP_LBU: load = {24'h0, model_mem[ad]};
                    mips_pkg::OP_LH:  load = {{16{model_mem[{ad[7:1], 1'b1}][7]}},
                                              model_mem[{ad[7:1], 1'b1}],
                                              model_mem[{ad[7:1], 1'b0}]};
                    mips_pkg::OP_LHU: load = {16'h0, model_mem[{ad[7:1], 1'b1}],
                                              model_mem[{ad[7:1], 1'b0}]};
                    default: load = {model_mem[{ad[7:2], 2'd3}], model_mem[{ad[7:2], 2'd2}],
                                     model_mem[{ad[7:2], 2'd1}], model_mem[{ad[7:2], 2'd0}]};
                endcase
            end
            mips_pkg::OP_SB, mips_pkg::OP_SH, mips_pkg::OP_SW: alu = a + sext;
            mips_pkg::OP_BEQ, mips_pkg::OP_BNE: begin
                alu     = a - b;
                r.taken = (ins[31:26] == mips_pkg::OP_BEQ) ? (a == b) : (a != b);
            end
            mips_pkg::OP_JAL: begin
                r.write  = 1'b1;
                r.wreg   = 5'd31;
                r.taken  = 1'b1;
                alu      = p + 32'd8;
                r.target = {p4[31:28], ins[25:0], 2'b00};
            end
            default: ;
        endcase
        if (fl) begin
            r.write = 1'b0; // Control cleared while data fields still load.
            r.taken = 1'b0;
        end
        r.data = (loadop && !fl) ? load : alu;
        return r;
    endfunction

    task automatic store_model(input logic [31:0] ins, input logic [31:0] a,
                               input logic [31:0] b);
        logic [31:0] alu;
        logic [7:0]  ad;
        alu = a + {{16{ins[15]}}, ins[15:0]};
        ad  = alu[7:0];
        case (ins[31:26])
            mips_pkg::OP_SB: model_mem[ad] = b[7:0];
            mips_pkg::OP_SH: begin
                model_mem[{ad[7:1], 1'b0}] = b[7:0];
                model_mem[{ad[7:1], 1'b1}] = b[15:8];
            end
            mips_pkg::OP_SW: begin
                model_mem[{ad[7:2], 2'd0}] = b[7:0];
                model_mem[{ad[7:2], 2'd1}] = b[15:8];
                model_mem[{ad[7:2], 2'd2}] = b[23:16];
                model_mem[{ad[7:2], 2'd3}] = b[31:24];
            end
            default: ;
        endcase
    endtask

    task automatic schedule(input string name, input exp_t e, input int due);
        exp_q.push_back(e);
        due_q.push_back(due);
        name_q.push_back(name);
    endtask

    task automatic drive(input logic [31:0] ins, input logic [31:0] a, input logic [31:0] b,
                         input logic [31:0] p, input logic fl);
        @(negedge i_clock);
        instr   = ins;
        rs_data = a;
        rt_data = b;
        pc      = p;
        flush   = fl;
    endtask

    // In run mode the result shows one rising edge later.
    task automatic issue(input string name, input logic [31:0] ins, input logic [31:0] a,
                         input logic [31:0] b, input logic [31:0] p, input logic fl);
        exp_t e;
        drive(ins, a, b, p, fl);
        e = ref_result(ins, a, b, p, fl);
        schedule(name, e, cycles + 1);
        if (!fl) begin
            store_model(ins, a, b);
        end
        last_exp = e;
    endtask

    function automatic logic [31:0] r_word(logic [5:0] fn, logic [4:0] rd, logic [4:0] sh);
        return {mips_pkg::OP_RTYPE, 5'($urandom()), 5'($urandom()), rd, sh, fn};
    endfunction

    function automatic logic [31:0] i_word(logic [5:0] op, logic [4:0] rt, logic [15:0] imm);
        return {op, 5'($urandom()), rt, imm};
    endfunction

    initial begin
        exp_t e;
        forever begin
            @(posedge i_clock);
            #1;
            if (due_q.size() != 0 && due_q[0] == cycles) begin
                e = exp_q.pop_front();
                void'(due_q.pop_front());
                check(name_q[0], "wb_data", e.data, wb_data);
                check(name_q[0], "wb_reg", 32'(e.wreg), 32'(wb_reg));
                check(name_q[0], "wb_write", 32'(e.write), 32'(wb_write));
                check(name_q[0], "branch_taken", 32'(e.taken), 32'(branch_taken));
                check(name_q[0], "branch_target", e.target, branch_target);
                check(name_q[0], "halted", 32'(e.halt), 32'(halted));
                void'(name_q.pop_front());
            end
        end
    end

    initial begin
        logic [5:0]  r_fns [7];
        logic [5:0]  i_ops [4];
        logic [5:0]  st_ops [3];
        logic [5:0]  ld_ops [5];
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] base;
        logic [15:0] imm;
        logic [7:0]  ad;
        exp_t        hold;
        exp_t        e;
        int          sz;
        r_fns  = '{mips_pkg::FN_ADDU, mips_pkg::FN_SUBU, mips_pkg::FN_AND, mips_pkg::FN_OR,
                   mips_pkg::FN_XOR, mips_pkg::FN_SLT, mips_pkg::FN_SLL};
        i_ops  = '{mips_pkg::OP_ADDIU, mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_LUI};
        st_ops = '{mips_pkg::OP_SB, mips_pkg::OP_SH, mips_pkg::OP_SW};
        ld_ops = '{mips_pkg::OP_LB, mips_pkg::OP_LBU, mips_pkg::OP_LH, mips_pkg::OP_LHU,
                   mips_pkg::OP_LW};
        void'($urandom(72));
        i_reset       = 1'b1;
        instr         = '0;
        rs_data       = '0;
        rt_data       = '0;
        pc            = '0;
        flush         = 1'b0;
        cfg_write     = 1'b0;
        cfg_step_mode = 1'b0;
        step          = 1'b0;
        repeat (4) @(posedge i_clock);
        @(negedge i_clock);
        i_reset = 1'b0;

        // Known contents for every byte before random loads.
        for (int k = 0; k < 64; k++) begin
            ad = 8'(k*4);
            issue("fill", i_word(mips_pkg::OP_SW, 5'd1, {8'h0, ad}), 32'h0,
                  {~ad, ad ^ 8'h3c, ad + 8'h11, ad}, 32'h0, 1'b0);
        end
        for (int k = 0; k < 60; k++) begin
            issue("rtype", r_word(r_fns[$urandom() % 7], 5'($urandom()), 5'($urandom())),
                  $urandom(), $urandom(), {30'($urandom()), 2'b00}, 1'b0);
        end
        for (int k = 0; k < 40; k++) begin
            issue("imm", i_word(i_ops[$urandom() % 4], 5'($urandom()), 16'($urandom())),
                  $urandom(), $urandom(), 32'h40, 1'b0);
        end
        for (int k = 0; k < 30; k++) begin
            sz   = $urandom() % 3;
            imm  = {8'h0, 8'($urandom()) & ~8'((1 << sz) - 1)};
            base = {$urandom() & 32'hffffff00};
            issue("store", i_word(st_ops[sz], 5'd2, imm), base, $urandom(), 32'h80, 1'b0);
            for (int j = 0; j < 5; j++) begin
                issue("load", i_word(ld_ops[j], 5'($urandom()), imm), base, 32'h0,
                      32'h84, 1'b0);
            end
        end
        for (int k = 0; k < 20; k++) begin
            a = $urandom();
            b = ($urandom() % 2 == 0) ? a : $urandom();
            issue("branch", i_word((k % 2 == 0) ? mips_pkg::OP_BEQ : mips_pkg::OP_BNE,
                  5'($urandom()), 16'($urandom())), a, b, {30'($urandom()), 2'b00}, 1'b0);
        end
        for (int k = 0; k < 10; k++) begin
            issue("jal", {mips_pkg::OP_JAL, 26'($urandom())}, $urandom(), $urandom(),
                  {30'($urandom()), 2'b00}, 1'b0);
            issue("jr", r_word(mips_pkg::FN_JR, 5'd0, 5'd0), $urandom(), 32'h0,
                  {30'($urandom()), 2'b00}, 1'b0);
            issue("jalr", r_word(mips_pkg::FN_JALR, 5'($urandom()), 5'd0), $urandom(),
                  32'h0, {30'($urandom()), 2'b00}, 1'b0);
        end
        for (int k = 0; k < 10; k++) begin
            issue("flush_alu", r_word(r_fns[$urandom() % 7], 5'($urandom()), 5'd3),
                  $urandom(), $urandom(), 32'h100, 1'b1);
            issue("flush_jal", {mips_pkg::OP_JAL, 26'($urandom())}, 32'h0, 32'h0,
                  32'h104, 1'b1);
            imm = {8'h0, 8'($urandom()) & 8'hfc};
            issue("flush_store", i_word(mips_pkg::OP_SW, 5'd4, imm), 32'h0, $urandom(),
                  32'h108, 1'b1);
            issue("flush_reload", i_word(mips_pkg::OP_LW, 5'd5, imm), 32'h0, 32'h0,
                  32'h10c, 1'b0);
        end

        issue("step_base", r_word(mips_pkg::FN_ADDU, 5'd3, 5'd0), 32'd1, 32'd2,
              32'h200, 1'b0);
        @(negedge i_clock);
        cfg_write     = 1'b1;
        cfg_step_mode = 1'b1;
        @(negedge i_clock);
        cfg_write = 1'b0;
        for (int k = 0; k < 3; k++) begin
            hold = last_exp;
            a    = $urandom();
            b    = $urandom();
            drive(r_word(mips_pkg::FN_ADDU, 5'($urandom()), 5'd0), a, b, 32'h204, 1'b0);
            e = ref_result(instr, a, b, 32'h204, 1'b0);
            schedule("step_hold", hold, cycles + 1);
            schedule("step_hold", hold, cycles + 2);
            schedule("step_hold", hold, cycles + 3);
            repeat (2) @(negedge i_clock);
            @(negedge i_clock);
            step = 1'b1;
            schedule("step_hold", hold, cycles + 1);
            schedule("step_load", e, cycles + 2); // Enable high one cycle after the pulse.
            @(negedge i_clock);
            step     = 1'b0;
            last_exp = e;
        end
        @(negedge i_clock);
        cfg_write     = 1'b1;
        cfg_step_mode = 1'b0;
        @(negedge i_clock);
        cfg_write = 1'b0;

        issue("halt", {mips_pkg::OP_HLT, 26'h0}, 32'h0, 32'h0, 32'h300, 1'b0);
        hold = last_exp;
        for (int k = 0; k < 6; k++) begin
            drive(r_word(mips_pkg::FN_ADDU, 5'($urandom()), 5'd0), $urandom(), $urandom(),
                  32'h304, 1'b0);
            schedule("halt_hold", hold, cycles + 1);
        end

        while (due_q.size() != 0) begin
            @(posedge i_clock);
        end
        @(negedge i_clock);
        $display("test passed");
        $finish;
    end

endmodule

/* filelist.f */
mips_pkg.sv
mem_pkg.sv
ex_stage.sv
ex_mem_reg.sv
mem_stage.sv
debug_ctrl.sv
ex_mem_top.sv
tb_ex_mem.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the EX/MEM testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --top-module tb_ex_mem -f filelist.f -o sim_tb_ex_mem
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb_ex_mem > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "test failed" sim.log; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
grep -q "test passed" sim.log || exit 1
exit 0
